/* list.f */
rp_pkg.sv
lutram_dual_port.sv
ex_branch_classify.sv
rpct.sv
ret_addr_stack.sv
return_predictor.sv
return_predictor_chk.sv
tb_return_predictor.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_return_predictor -o sim_return_predictor

./obj_dir/sim_return_predictor | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
exit 1

/* tb_return_predictor.sv */
`timescale 1ns/1ps

module tb_return_predictor import rp_pkg::*; ();

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_ROWS  = 200;

    // how a row's instruction word was built
    localparam int K_ALU      = 0;
    localparam int K_JAL      = 1;
    localparam int K_JALR     = 2;
    localparam int K_JALR_RA  = 3;
    localparam int K_JR_RA    = 4;
    localparam int K_JR_OTHER = 5;

    logic   clk;
    logic   rst_n;
    addr_t  fetch_pc;
    logic   ex_valid;
    addr_t  ex_pc;
    instr_u ex_instr;
    logic   hit_pc;
    logic   hit_pcp4;
    logic   hit;
    logic   ras_valid;
    addr_t  ras_target;

    // stimulus columns
    logic  row_valid [$];
    int    row_kind [$];
    addr_t row_pc [$];
    addr_t row_fpc [$];

    // expected columns, filled by the reference model
    logic  exp_hit_pc [$];
    logic  exp_hit_pcp4 [$];
    logic  exp_ras_valid [$];
    addr_t exp_ras_target [$];

    // shadow tag table and stack
    logic [RPCT_TAG_BITS-1:0] m_tag [RPCT_SETS][RPCT_WAYS];
    bit    m_valid [RPCT_SETS][RPCT_WAYS];
    bit    m_plru [RPCT_SETS];
    addr_t m_stack [RAS_DEPTH];
    int    m_top;
    int    m_count;

    int     errors;
    int     checks;
    int     limit_ns;
    integer seed;
    bit     table_ready;

    return_predictor dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_pc  (fetch_pc),
        .ex_valid  (ex_valid),
        .ex_pc     (ex_pc),
        .ex_instr  (ex_instr),
        .hit_pc    (hit_pc),
        .hit_pcp4  (hit_pcp4),
        .hit       (hit),
        .ras_valid (ras_valid),
        .ras_target(ras_target)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic instr_u encode_instr(int kind);
        instr_u i;
        i = '0;
        i.r.opcode = OP_SPECIAL;
        case (kind)
            K_JAL: begin
                i.j.opcode = OP_JAL;
                i.j.target = 26'h012_3456;
            end
            K_JALR: begin
                i.r.rs    = 5'd5;
                i.r.rd    = REG_RA;
                i.r.funct = FUNCT_JALR;
            end
            K_JALR_RA: begin
                i.r.rs    = REG_RA;
                i.r.rd    = REG_RA;
                i.r.funct = FUNCT_JALR;
            end
            K_JR_RA: begin
                i.r.rs    = REG_RA;
                i.r.funct = FUNCT_JR;
            end
            K_JR_OTHER: begin
                i.r.rs    = 5'd4;
                i.r.funct = FUNCT_JR;
            end
            default: begin
                // addu $10, $8, $9
                i.r.rs    = 5'd8;
                i.r.rt    = 5'd9;
                i.r.rd    = 5'd10;
                i.r.funct = 6'h21;
            end
        endcase
        return i;
    endfunction

    // set index is a[4:2], tag is a[31:5]
    function automatic int find_way(addr_t a);
        int idx;
        idx = int'(a[4:2]);
        for (int w = 0; w < RPCT_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == a[31:5]) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic add_row(logic v, int kind, addr_t pc, addr_t fpc);
        row_valid.push_back(v);
        row_kind.push_back(kind);
        row_pc.push_back(pc);
        row_fpc.push_back(fpc);
    endtask

    task automatic build_table();
        addr_t       pool [8];
        logic [31:0] rnd;
        int          kind;
        // idle lookups right after reset
        for (int i = 0; i < 4; i++) begin
            add_row(1'b0, K_JAL, 32'h100 + i * 32'h4, 32'h1000 + i * 32'h8);
        end
        // one return at 0x1010, then pc, pc+4 and same-set lookups
        add_row(1'b1, K_JR_RA, 32'h1010, 32'h0);
        add_row(1'b0, K_ALU, 32'h0, 32'h1010);
        add_row(1'b0, K_ALU, 32'h0, 32'h100c);
        add_row(1'b0, K_ALU, 32'h0, 32'h1210);
        add_row(1'b0, K_ALU, 32'h0, 32'h120c);
        // three returns in set 2, the third evicts the first
        add_row(1'b1, K_JR_RA, 32'h2008, 32'h0);
        add_row(1'b1, K_JR_RA, 32'h3008, 32'h0);
        add_row(1'b1, K_JR_RA, 32'h4008, 32'h0);
        add_row(1'b0, K_ALU, 32'h0, 32'h2008);
        add_row(1'b0, K_ALU, 32'h0, 32'h3008);
        add_row(1'b0, K_ALU, 32'h0, 32'h4008);
        // set 3, a fetch hit moves the victim
        add_row(1'b1, K_JR_RA, 32'h500c, 32'h0);
        add_row(1'b1, K_JR_RA, 32'h600c, 32'h0);
        add_row(1'b0, K_ALU, 32'h0, 32'h500c);
        add_row(1'b1, K_JR_RA, 32'h700c, 32'h0);
        add_row(1'b0, K_ALU, 32'h0, 32'h600c);
        // plru now names 0x500c, the re-record must not take it
        add_row(1'b0, K_ALU, 32'h0, 32'h700c);
        add_row(1'b1, K_JR_RA, 32'h700c, 32'h0);
        add_row(1'b0, K_ALU, 32'h0, 32'h500c);
        add_row(1'b0, K_ALU, 32'h0, 32'h700c);
        // pushes and pops, ending with a pop on an empty stack
        add_row(1'b1, K_JAL, 32'h400, 32'h0);
        add_row(1'b1, K_JALR, 32'h500, 32'h0);
        add_row(1'b1, K_JR_RA, 32'h600, 32'h0);
        add_row(1'b1, K_JALR_RA, 32'h700, 32'h0);
        add_row(1'b1, K_JR_RA, 32'h604, 32'h0);
        add_row(1'b1, K_JR_RA, 32'h608, 32'h0);
        add_row(1'b1, K_JR_RA, 32'h60c, 32'h0);
        add_row(1'b0, K_ALU, 32'h0, 32'h0);
        // nine pushes overflow by one, then eight pops
        for (int i = 0; i < 9; i++) begin
            add_row(1'b1, K_JAL, 32'h8000 + i * 32'h40, 32'h0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row(1'b1, K_JR_RA, 32'h9000 + i * 32'h24, 32'h0);
            add_row(1'b1, K_ALU, 32'h9800, 32'h0);
            add_row(1'b0, K_JAL, 32'h9900, 32'h0);
            add_row(1'b1, K_JR_OTHER, 32'h9a00, 32'h0);
            add_row(1'b0, K_JR_RA, 32'h9b00, 32'h0);
        end
        add_row(1'b0, K_ALU, 32'h0, 32'h0);

        // small pc pool, sets 0 and 1 collide
        pool = '{32'h100, 32'h120, 32'h140, 32'h1100,
                 32'h104, 32'h904, 32'h1004, 32'h2104};
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            rnd = $random(seed);
            if (rnd[3:0] < 4'd5) begin
                kind = K_JAL;
            end else if (rnd[3:0] < 4'd10) begin
                kind = K_JR_RA;
            end else if (rnd[3:0] < 4'd14) begin
                kind = K_ALU;
            end else if (rnd[3:0] == 4'd14) begin
                kind = K_JALR;
            end else begin
                kind = K_JR_OTHER;
            end
            add_row(rnd[4] | rnd[5], kind, pool[rnd[8:6]],
                    pool[rnd[11:9]] - (rnd[12] ? 32'd4 : 32'd0));
        end
    endtask

    // walk the table once, expected outputs come before each row's update
    task automatic build_expected();
        addr_t pcp4;
        int way_pc;
        int way_p4;
        int fidx;
        int fway;
        int ridx;
        int rway;
        bit fupd;
        bit is_push;
        bit is_pop;
        for (int s = 0; s < RPCT_SETS; s++) begin
            m_plru[s] = 1'b0;
            for (int w = 0; w < RPCT_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
        m_top   = 0;
        m_count = 0;
        for (int r = 0; r < row_kind.size(); r++) begin
            pcp4   = row_fpc[r] + 32'd4;
            way_pc = find_way(row_fpc[r]);
            way_p4 = find_way(pcp4);
            exp_hit_pc.push_back(way_pc >= 0);
            exp_hit_pcp4.push_back(way_p4 >= 0);
            exp_ras_valid.push_back(m_count != 0);
            exp_ras_target.push_back(m_stack[m_top]);

            is_push = row_valid[r] && (row_kind[r] == K_JAL || row_kind[r] == K_JALR
                                       || row_kind[r] == K_JALR_RA);
            is_pop  = row_valid[r] && (row_kind[r] == K_JR_RA);

            fupd = 1'b1;
            fidx = 0;
            fway = 0;
            if (way_pc >= 0) begin
                fidx = int'(row_fpc[r][4:2]);
                fway = way_pc;
            end else if (way_p4 >= 0) begin
                fidx = int'(pcp4[4:2]);
                fway = way_p4;
            end else begin
                fupd = 1'b0;
            end
            ridx = int'(row_pc[r][4:2]);

            // a record in the same set wins over the fetch touch
            if (fupd && !(is_pop && ridx == fidx)) begin
                m_plru[fidx] = (fway == 0);
            end
            if (is_pop && find_way(row_pc[r]) < 0) begin
                rway = m_plru[ridx] ? 1 : 0;
                m_tag[ridx][rway]   = row_pc[r][31:5];
                m_valid[ridx][rway] = 1'b1;
                m_plru[ridx]        = (rway == 0);
            end

            if (is_push) begin
                m_top = (m_top + 1) % RAS_DEPTH;
                m_stack[m_top] = row_pc[r] + 32'd8;
                if (m_count < RAS_DEPTH) begin
                    m_count++;
                end
            end else if (is_pop && m_count > 0) begin
                m_top = (m_top + RAS_DEPTH - 1) % RAS_DEPTH;
                m_count--;
            end
        end
    endtask

    task automatic apply_row(int r);
        ex_valid = row_valid[r];
        ex_instr = encode_instr(row_kind[r]);
        ex_pc    = row_pc[r];
        fetch_pc = row_fpc[r];
    endtask

    task automatic compare_value(string name, int r, logic [31:0] got, logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("** Error row %0d: %s = 0x%h, expected 0x%h", r, name, got, want);
            errors++;
        end
    endtask

    task automatic check_row(int r);
        compare_value("hit_pc", r, 32'(hit_pc), 32'(exp_hit_pc[r]));
        compare_value("hit_pcp4", r, 32'(hit_pcp4), 32'(exp_hit_pcp4[r]));
        compare_value("hit", r, 32'(hit), 32'(exp_hit_pc[r] | exp_hit_pcp4[r]));
        compare_value("ras_valid", r, 32'(ras_valid), 32'(exp_ras_valid[r]));
        if (exp_ras_valid[r]) begin
            compare_value("ras_target", r, ras_target, exp_ras_target[r]);
        end
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        seed        = 68207;
        table_ready = 1'b0;
        rst_n       = 1'b0;
        fetch_pc    = '0;
        ex_valid    = 1'b0;
        ex_pc       = '0;
        ex_instr    = '0;
        build_table();
        build_expected();
        limit_ns    = (row_kind.size() + RESET_CYCLES + 20) * PERIOD;
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < row_kind.size(); r++) begin
            if (r != 0) begin
                @(posedge clk);
                #1;
            end
            apply_row(r);
            // sample one ns before the next edge
            #(PERIOD - 2);
            check_row(r);
        end
        @(posedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(limit_ns);
        $display("watchdog expired before all table rows were applied");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* return_predictor_chk.sv */
`timescale 1ns/1ps

// protocol checks on the predictor top level
module return_predictor_chk (
    input logic clk,
    input logic rst_n,
    input logic hit_pc,
    input logic hit_pcp4,
    input logic hit,
    input logic ras_valid,
    input logic ras_push
);

    hit_is_or: assert property (
        @(posedge clk) disable iff (!rst_n) hit == (hit_pc | hit_pcp4)
    ) else $error("hit does not match hit_pc | hit_pcp4");

    // table and stack start out empty
    clear_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (!hit && !ras_valid)
    ) else $error("hit or ras_valid set in the first cycle after reset");

    ras_valid_needs_push: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ras_valid) |-> $past(ras_push)
    ) else $error("ras_valid rose without a push in the prior cycle");

endmodule

bind return_predictor return_predictor_chk chk_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .hit_pc   (hit_pc),
    .hit_pcp4 (hit_pcp4),
    .hit      (hit),
    .ras_valid(ras_valid),
    .ras_push (ras_push)
);

/* return_predictor.sv */
`timescale 1ns/1ps

// return prediction for fetch
// rpct flags returns at pc or pc+4, the stack gives the target
module return_predictor import rp_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,

    // fetch side
    input  addr_t  fetch_pc,

    // execute side
    input  logic   ex_valid,
    input  addr_t  ex_pc,
    input  instr_u ex_instr,

    output logic   hit_pc,
    output logic   hit_pcp4,
    output logic   hit,
    output logic   ras_valid,
    output addr_t  ras_target
);

    logic  ras_push;
    // a jr $ra pops the stack and is recorded in the rpct
    logic  ras_pop;
    addr_t link_addr;

    ex_branch_classify classify_i (
        .ex_valid (ex_valid),
        .ex_pc    (ex_pc),
        .ex_instr (ex_instr),
        .ras_push (ras_push),
        .ras_pop  (ras_pop),
        .link_addr(link_addr)
    );

    rpct rpct_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch_pc (fetch_pc),
        .record   (ras_pop),
        .record_pc(ex_pc),
        .hit_pc   (hit_pc),
        .hit_pcp4 (hit_pcp4),
        .hit      (hit)
    );

    ret_addr_stack ras_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (ras_push),
        .pop      (ras_pop),
        .push_addr(link_addr),
        .valid    (ras_valid),
        .top      (ras_target)
    );

endmodule

/* ret_addr_stack.sv */
`timescale 1ns/1ps

// circular return address stack
// overflow drops the oldest entry, underflow is ignored
module ret_addr_stack import rp_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  logic  push,
    input  logic  pop,
    input  addr_t push_addr,

    output logic  valid,
    output addr_t top
);

    typedef logic [RAS_PTR_BITS-1:0] ptr_t;
    // one bit wider than the pointer, holds 0..RAS_DEPTH
    typedef logic [RAS_PTR_BITS:0]   count_t;

    addr_t  stack_mem [RAS_DEPTH];
    ptr_t   top_ptr;
    ptr_t   push_ptr;
    count_t count;
    logic   not_empty;

    assign push_ptr  = top_ptr + 1'b1;
    assign not_empty = (count != '0);

    // link addresses, written one slot above the top
    always_ff @(posedge clk) begin
        if (push) begin
            stack_mem[push_ptr] <= push_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (push) begin
            top_ptr <= push_ptr;
            // saturate, the wrapped write has replaced the oldest entry
            if (count != count_t'(RAS_DEPTH)) begin
                count <= count + 1'b1;
            end
        end else if (pop && not_empty) begin
            top_ptr <= top_ptr - 1'b1;
            count   <= count - 1'b1;
        end
    end

    assign valid = not_empty;
    assign top   = stack_mem[top_ptr];

endmodule

/* rpct.sv */
`timescale 1ns/1ps

// return-pc tag table, two ways, one plru bit per set
module rpct import rp_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  addr_t fetch_pc,

    input  logic  record,
    input  addr_t record_pc,

    output logic  hit_pc,
    output logic  hit_pcp4,
    output logic  hit
);

    typedef logic [RPCT_INDEX_BITS-1:0] index_t;
    typedef logic [RPCT_TAG_BITS-1:0]   tag_t;
    typedef logic [RPCT_WAYS-1:0][RPCT_TAG_BITS-1:0] set_tags_t;

    function automatic index_t get_index(addr_t addr);
        return addr[RPCT_INDEX_BITS+1:2];
    endfunction

    function automatic tag_t get_tag(addr_t addr);
        return addr[31:RPCT_INDEX_BITS+2];
    endfunction

    // per-set valid bits and plru state
    logic [RPCT_SETS-1:0][RPCT_WAYS-1:0] valid_q;
    logic [RPCT_SETS-1:0]                plru_q;

    addr_t  fetch_pcp4;
    index_t idx_pc, idx_pcp4, rec_idx;
    tag_t   rec_tag;

    set_tags_t tags_pc, tags_pcp4, rec_tags, rec_wdata;

    logic [RPCT_WAYS-1:0] way_hit_pc, way_hit_pcp4, rec_match;
    logic rec_way;
    logic rec_alloc;
    logic fetch_upd;
    logic fetch_way;
    index_t fetch_idx;

    assign fetch_pcp4 = fetch_pc + 32'd4;
    assign idx_pc     = get_index(fetch_pc);
    assign idx_pcp4   = get_index(fetch_pcp4);
    assign rec_idx    = get_index(record_pc);
    assign rec_tag    = get_tag(record_pc);

    // tag copy for the fetch pc, its port 1 serves the record path
    lutram_dual_port #(
        .addr_bits(RPCT_INDEX_BITS),
        .data_bits(RPCT_WAYS * RPCT_TAG_BITS)
    ) tags_cur (
        .clk    (clk),
        .we     (record),
        .addr_1 (rec_idx),
        .wdata  (rec_wdata),
        .rdata_1(rec_tags),
        .addr_2 (idx_pc),
        .rdata_2(tags_pc)
    );

    // identical copy, second read port looks at pc+4
    lutram_dual_port #(
        .addr_bits(RPCT_INDEX_BITS),
        .data_bits(RPCT_WAYS * RPCT_TAG_BITS)
    ) tags_next (
        .clk    (clk),
        .we     (record),
        .addr_1 (rec_idx),
        .wdata  (rec_wdata),
        .rdata_1(),
        .addr_2 (idx_pcp4),
        .rdata_2(tags_pcp4)
    );

    // tag compare, pc+4 may land in another set with another tag
    always_comb begin
        for (int w = 0; w < RPCT_WAYS; w++) begin
            way_hit_pc[w]   = valid_q[idx_pc][w] && (tags_pc[w] == get_tag(fetch_pc));
            way_hit_pcp4[w] = valid_q[idx_pcp4][w] && (tags_pcp4[w] == get_tag(fetch_pcp4));
            rec_match[w]    = valid_q[rec_idx][w] && (rec_tags[w] == rec_tag);
        end
    end

    assign hit_pc   = |way_hit_pc;
    assign hit_pcp4 = |way_hit_pcp4;
    assign hit      = hit_pc | hit_pcp4;

    // an existing tag is rewritten in place, else the plru victim
    assign rec_alloc = ~|rec_match;
    assign rec_way   = rec_alloc ? plru_q[rec_idx] : rec_match[1];

    always_comb begin
        rec_wdata = rec_tags;
        rec_wdata[rec_way] = rec_tag;
    end

    // fetch side touch, pc wins over pc+4
    assign fetch_upd = hit_pc | hit_pcp4;
    assign fetch_idx = hit_pc ? idx_pc : idx_pcp4;
    assign fetch_way = hit_pc ? way_hit_pc[1] : way_hit_pcp4[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            plru_q  <= '0;
        end else begin
            // record owns the set when both touch it
            if (fetch_upd && !(record && rec_idx == fetch_idx)) begin
                plru_q[fetch_idx] <= ~fetch_way;
            end
            if (record) begin
                valid_q[rec_idx][rec_way] <= 1'b1;
                // rewrite of a known return leaves the plru alone
                if (rec_alloc) begin
                    plru_q[rec_idx] <= ~rec_way;
                end
            end
        end
    end

endmodule

/* ex_branch_classify.sv */
`timescale 1ns/1ps

// execute-side decode of a resolved instruction
// jal/jalr push the link address, jr $ra pops and is recorded
module ex_branch_classify import rp_pkg::*; (
    input  logic   ex_valid,
    input  addr_t  ex_pc,
    input  instr_u ex_instr,

    output logic   ras_push,
    output logic   ras_pop,
    output addr_t  link_addr
);

    logic is_special;
    logic is_jr_ra;
    logic is_jalr;
    logic is_jal;

    // register format view
    assign is_special = (ex_instr.r.opcode == OP_SPECIAL);

    assign is_jr_ra = is_special
                   && (ex_instr.r.funct == FUNCT_JR)
                   && (ex_instr.r.rs == REG_RA);

    // any source register, jalr $ra still links
    assign is_jalr = is_special && (ex_instr.r.funct == FUNCT_JALR);

    // jump format view, only the opcode matters here
    assign is_jal = (ex_instr.j.opcode == OP_JAL);

    assign ras_push = ex_valid && (is_jal || is_jalr);
    assign ras_pop  = ex_valid && is_jr_ra;

    // return lands after the delay slot
    assign link_addr = ex_valid ? (ex_pc + 32'd8) : '0;

endmodule

/* lutram_dual_port.sv */
`timescale 1ns/1ps

// small distributed memory
// port 1 writes on the clock edge and reads asynchronously,
// port 2 is a second asynchronous read port
module lutram_dual_port #(
    parameter int addr_bits = 3,
    parameter int data_bits = 32
) (
    input  logic                 clk,

    input  logic                 we,
    input  logic [addr_bits-1:0] addr_1,
    input  logic [data_bits-1:0] wdata,
    output logic [data_bits-1:0] rdata_1,

    input  logic [addr_bits-1:0] addr_2,
    output logic [data_bits-1:0] rdata_2
);

    localparam int depth = 2 ** addr_bits;

    logic [data_bits-1:0] mem [depth];

    // contents stay undefined until a location is written
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr_1] <= wdata;
        end
    end

    // zero-latency reads
    assign rdata_1 = mem[addr_1];
    assign rdata_2 = mem[addr_2];

endmodule

/* rp_pkg.sv */
package rp_pkg;

    // byte address as seen by fetch and execute
    typedef logic [31:0] addr_t;

    // return-pc tag table geometry
    localparam int RPCT_WAYS       = 2;
    localparam int RPCT_SETS       = 8;
    localparam int RPCT_INDEX_BITS = 3;
    localparam int RPCT_TAG_BITS   = 27;

    // return address stack geometry
    localparam int RAS_DEPTH    = 8;
    localparam int RAS_PTR_BITS = 3;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_JAL     = 6'h03;

    // special-class function codes
    localparam logic [5:0] FUNCT_JR   = 6'h08;
    localparam logic [5:0] FUNCT_JALR = 6'h09;

    // link register
    localparam logic [4:0] REG_RA = 5'd31;

    // one instruction word, seen as register or jump format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_u;

endpackage
